// File: Makefile
SRCS := $(shell cat filelist.f)

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_uart: filelist.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_uart -f filelist.f -o Vtb_uart

run: obj_dir/Vtb_uart
	./obj_dir/Vtb_uart | tee sim.log
	grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: filelist.f
rtl/uart_pkg.sv
rtl/uart_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/rx_fifo.sv
rtl/uart.sv
test/tb_uart.sv

// File: rtl/rx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module rx_fifo
   (
   input  wire logic                                  clk,
   input  wire logic                                  reset,
   input  wire logic                                  wr,
   input  wire logic [7:0]                            din,
   input  wire logic                                  rd,
   output logic      [7:0]                            dout,
   output logic                                       empty,
   output logic                                       full,
   output logic      [uart_pkg::queue_addr_width-1:0] raddr,
   output logic      [uart_pkg::queue_addr_width-1:0] waddr
   );

   import uart_pkg::*;

   logic [7:0]                mem [0:(1 << queue_addr_width)-1];
   logic [queue_addr_width:0] count;   // One extra bit to tell full from empty
   logic                      do_wr;
   logic                      do_rd;

   assign do_wr = wr & ~full;    // Dropped when full
   assign do_rd = rd & ~empty;

   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[waddr] <= din;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         raddr <= '0;
         waddr <= '0;
         count <= '0;
      end
      else
      begin
         if (do_wr)
            waddr <= waddr + queue_addr_width'(1);
         if (do_rd)
            raddr <= raddr + queue_addr_width'(1);
         case ({do_wr, do_rd})
            2'b10:   count <= count + (queue_addr_width + 1)'(1);
            2'b01:   count <= count - (queue_addr_width + 1)'(1);
            default: count <= count;
         endcase
      end
   end

   assign dout  = mem[raddr];
   assign empty = (count == '0);
   assign full  = count[queue_addr_width];

endmodule

`default_nettype wire

// File: rtl/uart.sv
`timescale 1ns/1ps
`default_nettype none

module uart
   (
   input  wire logic                            clk,
   input  wire logic                            reset,
   input  wire logic                            cs,
   input  wire logic                            wen,
   input  wire logic [uart_pkg::addr_width-1:0] addr,
   input  wire logic [uart_pkg::data_width-1:0] din,
   output logic      [uart_pkg::data_width-1:0] dout,
   input  wire logic                            rxd,
   output logic                                 txd
   );

   import uart_pkg::*;

   logic                        rx_en;
   logic                        tx_en;
   logic [data_width-1:0]       cycles_per_bit;
   logic                        tx_start;
   logic [7:0]                  tx_data;
   logic                        tx_busy;
   logic                        pop;
   logic                        rx_valid;
   logic                        rx_break;
   logic [7:0]                  rx_data;
   logic [data_width-1:0]       char_count;
   logic [7:0]                  q_data;
   logic                        empty;
   logic                        full;
   logic [queue_addr_width-1:0] raddr;
   logic [queue_addr_width-1:0] waddr;

   uart_regs u_regs (.clk(clk), .reset(reset), .cs(cs), .wen(wen), .addr(addr), .din(din),
      .dout(dout), .tx_busy(tx_busy), .rx_valid(rx_valid), .rx_break(rx_break),
      .char_count(char_count), .q_data(q_data), .empty(empty), .full(full), .raddr(raddr),
      .waddr(waddr), .rx_en(rx_en), .tx_en(tx_en), .cycles_per_bit(cycles_per_bit),
      .tx_start(tx_start), .tx_data(tx_data), .pop(pop));

   uart_tx u_tx (.clk(clk), .reset(reset), .tx_start(tx_start), .tx_data(tx_data),
      .cycles_per_bit(cycles_per_bit), .txd(txd), .tx_busy(tx_busy));

   uart_rx u_rx (.clk(clk), .reset(reset), .rxd(rxd), .rx_en(rx_en),
      .cycles_per_bit(cycles_per_bit), .rx_valid(rx_valid), .rx_break(rx_break),
      .rx_data(rx_data), .char_count(char_count));

   // Received bytes queue until software pops them
   rx_fifo u_fifo (.clk(clk), .reset(reset), .wr(rx_valid), .din(rx_data), .rd(pop),
      .dout(q_data), .empty(empty), .full(full), .raddr(raddr), .waddr(waddr));

endmodule

`default_nettype wire

// File: rtl/uart_pkg.sv
`default_nettype none

package uart_pkg;

   localparam int data_width       = 32;
   localparam int addr_width       = 4;
   localparam int queue_addr_width = 7;    // 128 receive entries

   // Register map
   localparam logic [addr_width-1:0] reg_dr         = 4'd0;
   localparam logic [addr_width-1:0] reg_ctrl       = 4'd1;
   localparam logic [addr_width-1:0] reg_rstat      = 4'd2;
   localparam logic [addr_width-1:0] reg_tstat      = 4'd3;
   localparam logic [addr_width-1:0] reg_cpb        = 4'd4;
   localparam logic [addr_width-1:0] reg_queue      = 4'd5;   // Peek at queue head
   localparam logic [addr_width-1:0] reg_pop        = 4'd6;   // Write pops the queue
   localparam logic [addr_width-1:0] reg_char_count = 4'd7;

   localparam int ctrl_rx_en = 0;
   localparam int ctrl_tx_en = 1;

   // Receive status flags below the head byte and pointers
   localparam int stat_rxne     = 0;
   localparam int stat_break    = 1;
   localparam int stat_rx_valid = 2;
   localparam int stat_full     = 5;

   localparam int stat_tc = 0;    // Transmitter idle

   localparam logic [data_width-1:0] cpb_reset = 32'd217;   // 25 MHz to 115200 baud

   // Receiver FSM states
   localparam logic [2:0] rx_idle     = 3'd0;
   localparam logic [2:0] rx_start    = 3'd1;
   localparam logic [2:0] rx_data_st  = 3'd2;
   localparam logic [2:0] rx_stop     = 3'd3;
   localparam logic [2:0] rx_brk_wait = 3'd4;

endpackage

`default_nettype wire

// File: rtl/uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_regs
   (
   input  wire logic                                  clk,
   input  wire logic                                  reset,
   input  wire logic                                  cs,
   input  wire logic                                  wen,
   input  wire logic [uart_pkg::addr_width-1:0]       addr,
   input  wire logic [uart_pkg::data_width-1:0]       din,
   output logic      [uart_pkg::data_width-1:0]       dout,
   input  wire logic                                  tx_busy,
   input  wire logic                                  rx_valid,
   input  wire logic                                  rx_break,
   input  wire logic [uart_pkg::data_width-1:0]       char_count,
   input  wire logic [7:0]                            q_data,
   input  wire logic                                  empty,
   input  wire logic                                  full,
   input  wire logic [uart_pkg::queue_addr_width-1:0] raddr,
   input  wire logic [uart_pkg::queue_addr_width-1:0] waddr,
   output logic                                       rx_en,
   output logic                                       tx_en,
   output logic      [uart_pkg::data_width-1:0]       cycles_per_bit,
   output logic                                       tx_start,
   output logic      [7:0]                            tx_data,
   output logic                                       pop
   );

   import uart_pkg::*;

   logic                  wr;
   logic [data_width-1:0] control;
   logic [data_width-1:0] scratch [0:3];
   logic [data_width-1:0] rstat;
   logic [data_width-1:0] tstat;

   assign wr = cs & wen;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         control        <= '0;
         cycles_per_bit <= cpb_reset;
         for (int i = 0; i < 4; i++)
            scratch[i] <= '0;
      end
      else if (wr)
      begin
         if (addr == reg_ctrl)
            control <= din;
         if (addr == reg_cpb)
            cycles_per_bit <= din;
         if (addr[3:2] == 2'b11)    // Scratch at 12..15
            scratch[addr[1:0]] <= din;
      end
   end

   assign rx_en    = control[ctrl_rx_en];
   assign tx_en    = control[ctrl_tx_en];
   assign tx_start = wr & (addr == reg_dr) & tx_en;   // Dropped by the engine if busy
   assign tx_data  = din[7:0];
   assign pop      = wr & (addr == reg_pop);

   always_comb
   begin
      rstat                = '0;
      rstat[stat_rxne]     = ~empty;
      rstat[stat_break]    = rx_break;
      rstat[stat_rx_valid] = rx_valid;
      rstat[stat_full]     = full;
      rstat[15:8]          = q_data;
      rstat[22:16]         = waddr;
      rstat[30:24]         = raddr;
      tstat                = '0;
      tstat[stat_tc]       = ~tx_busy;
   end

   // Zero-latency read mux
   always_comb
   begin
      case (addr)
         reg_dr, reg_queue : dout = {24'd0, q_data};
         reg_ctrl          : dout = control;
         reg_rstat         : dout = rstat;
         reg_tstat         : dout = tstat;
         reg_cpb           : dout = cycles_per_bit;
         reg_char_count    : dout = char_count;
         default:
         begin
            if (addr[3:2] == 2'b11)
               dout = scratch[addr[1:0]];
            else
               dout = '0;       // Unmapped
         end
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx
   (
   input  wire logic                            clk,
   input  wire logic                            reset,
   input  wire logic                            rxd,
   input  wire logic                            rx_en,
   input  wire logic [uart_pkg::data_width-1:0] cycles_per_bit,
   output logic                                 rx_valid,
   output logic                                 rx_break,
   output logic      [7:0]                      rx_data,
   output logic      [uart_pkg::data_width-1:0] char_count
   );

   import uart_pkg::*;

   logic                  rxd_meta;
   logic                  rxd_sync;
   logic                  rxd_prev;
   logic [2:0]            state;
   logic [data_width-1:0] cnt;
   logic [2:0]            bit_idx;
   logic [7:0]            shift;

   // Synchronizer plus one stage for edge detect
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_prev <= 1'b1;
      end
      else
      begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= rx_idle;
         cnt      <= '0;
         bit_idx  <= '0;
         rx_valid <= 1'b0;
         rx_break <= 1'b0;
      end
      else
      begin
         rx_valid <= 1'b0;
         if (state != rx_idle && state != rx_brk_wait && cnt != '0)
            cnt <= cnt - 32'd1;
         else
            case (state)
               rx_idle:
                  if (rx_en && rxd_prev && !rxd_sync)
                  begin
                     state <= rx_start;
                     cnt   <= (cycles_per_bit >> 1) - 32'd1;   // Half a bit to centre
                  end
               rx_start:
               begin
                  state   <= rxd_sync ? rx_idle : rx_data_st;   // Glitch check
                  cnt     <= cycles_per_bit - 32'd1;
                  bit_idx <= '0;
               end
               rx_data_st:
               begin
                  bit_idx <= bit_idx + 3'd1;
                  cnt     <= cycles_per_bit - 32'd1;
                  if (bit_idx == 3'd7)
                     state <= rx_stop;
               end
               rx_stop:
                  if (rxd_sync)
                  begin
                     rx_valid <= 1'b1;
                     rx_break <= 1'b0;
                     state    <= rx_idle;
                  end
                  else if (shift == '0)
                  begin
                     rx_break <= 1'b1;
                     state    <= rx_brk_wait;
                  end
                  else
                     state <= rx_idle;   // Framing error drops the byte
               rx_brk_wait:
                  if (rxd_sync)
                     state <= rx_idle;
               default: state <= rx_idle;
            endcase
      end
   end

   // Payload shifts in LSB first
   always_ff @(posedge clk)
   begin
      if (state == rx_data_st && cnt == '0)
         shift <= {rxd_sync, shift[7:1]};
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         char_count <= '0;
      else if (rx_valid)
         char_count <= char_count + 32'd1;
   end

   assign rx_data = shift;

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx
   (
   input  wire logic                            clk,
   input  wire logic                            reset,
   input  wire logic                            tx_start,
   input  wire logic [7:0]                      tx_data,
   input  wire logic [uart_pkg::data_width-1:0] cycles_per_bit,
   output logic                                 txd,
   output logic                                 tx_busy
   );

   import uart_pkg::*;

   logic [9:0]            shift;       // Stop, data and start bits with the LSB on the line
   logic [3:0]            bits_left;
   logic [data_width-1:0] bit_cnt;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         shift     <= '1;
         bits_left <= '0;
         bit_cnt   <= '0;
         tx_busy   <= 1'b0;
      end
      else if (!tx_busy)
      begin
         if (tx_start)
         begin
            shift     <= {1'b1, tx_data, 1'b0};
            bits_left <= 4'd9;
            bit_cnt   <= cycles_per_bit - 32'd1;
            tx_busy   <= 1'b1;
         end
      end
      else if (bit_cnt == '0)
      begin
         shift   <= {1'b1, shift[9:1]};   // Fill with idle level
         bit_cnt <= cycles_per_bit - 32'd1;
         if (bits_left == '0)
            tx_busy <= 1'b0;              // Stop bit done
         else
            bits_left <= bits_left - 4'd1;
      end
      else
      begin
         bit_cnt <= bit_cnt - 32'd1;
      end
   end

   assign txd = shift[0];

endmodule

`default_nettype wire

// File: test/tb_uart.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart;

   import uart_pkg::*;

   localparam int bit_cycles  = 8;
   localparam int num_tests   = 5;
   localparam int max_frames  = 6;
   localparam int poll_limit  = 20 * bit_cycles;
   localparam int watchdog_ns = num_tests * max_frames * 10 * bit_cycles * 4 * 2;

   logic                  clk;
   logic                  reset;
   logic                  cs;
   logic                  wen;
   logic [addr_width-1:0] addr;
   logic [data_width-1:0] din;
   logic [data_width-1:0] dout;
   logic                  rxd;
   logic                  txd;

   int          errors     = 0;
   int          checks     = 0;
   int          tests_run  = 0;
   int          rx_total   = 0;    // Good frames sent while enabled
   logic [15:0] lfsr_state = 16'd89;

   uart UUT (.clk(clk), .reset(reset), .cs(cs), .wen(wen), .addr(addr), .din(din),
      .dout(dout), .rxd(rxd), .txd(txd));

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial
   begin
      #(watchdog_ns);
      $display("Watchdog expired at %0d ns, the run did not finish in time", $time);
      $display("*** TEST FAILED ***");
      $finish;
   end

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         v          = {v[30:0], lfsr_state[0]};
      end
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         $display("Fail at %0d ns: %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic test_done(input string name, input int errs_before);
      tests_run++;
      $display("%s: %0d errors", name, errors - errs_before);
   endtask

   // All bus tasks start and end 1 ns after a rising edge
   task automatic bus_write(input logic [3:0] a, input logic [31:0] d);
      cs   = 1'b1;
      wen  = 1'b1;
      addr = a;
      din  = d;
      @(posedge clk);
      #1;
      cs  = 1'b0;
      wen = 1'b0;
   endtask

   task automatic bus_read(input logic [3:0] a, output logic [31:0] d);
      cs   = 1'b1;
      wen  = 1'b0;
      addr = a;
      #1;
      d = dout;   // Combinational read settles well before the edge
      @(posedge clk);
      #1;
      cs = 1'b0;
   endtask

   task automatic wait_reg(input logic [3:0] a, input logic [31:0] mask,
                           input logic [31:0] value, input string what);
      logic [31:0] d;
      int          tries;
      tries = 0;
      bus_read(a, d);
      while ((d & mask) != value && tries < poll_limit)
      begin
         bus_read(a, d);
         tries++;
      end
      if ((d & mask) != value)
      begin
         $display("Timeout at %0d ns while waiting for %s", $time, what);
         errors++;
      end
   endtask

   task automatic send_byte(input logic [7:0] data, input logic stop);
      logic [9:0] frame;
      frame = {stop, data, 1'b0};
      for (int i = 0; i < 10; i++)
      begin
         rxd = frame[i];
         repeat (bit_cycles) @(posedge clk);
         #1;
      end
      rxd = 1'b1;
   endtask

   task automatic capture_byte(output logic [7:0] value, output logic start_bit,
                               output logic stop_bit);
      int waited;
      waited    = 0;
      value     = '0;
      start_bit = 1'b1;
      stop_bit  = 1'b0;
      while (txd !== 1'b0 && waited < 4 * bit_cycles)
      begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (txd !== 1'b0)
      begin
         $display("No start bit seen on txd by %0d ns", $time);
         errors++;
      end
      else
      begin
         repeat (bit_cycles / 2) @(posedge clk);   // To the centre of the start bit
         #1;
         start_bit = txd;
         for (int i = 0; i < 8; i++)
         begin
            repeat (bit_cycles) @(posedge clk);
            #1;
            value[i] = txd;
         end
         repeat (bit_cycles) @(posedge clk);
         #1;
         stop_bit = txd;
      end
   endtask

   task automatic test_reset_values();
      logic [31:0] d;
      int          e0;
      e0 = errors;
      bus_read(reg_ctrl, d);
      check("control", d, 32'd0);
      bus_read(reg_cpb, d);
      check("cycles_per_bit", d, 32'd217);
      bus_read(reg_tstat, d);
      check("tx status", d, 32'd1);
      bus_read(reg_rstat, d);
      check("rx status rxne", 32'(d[stat_rxne]), 32'd0);
      check("rx status full", 32'(d[stat_full]), 32'd0);
      bus_read(reg_char_count, d);
      check("char_count", d, 32'd0);
      for (int i = 12; i < 16; i++)
      begin
         bus_read(4'(i), d);
         check("scratch", d, 32'd0);
      end
      test_done("reset values", e0);
   endtask

   task automatic test_register_access();
      logic [31:0] d;
      logic [31:0] v;
      logic [31:0] scratch_exp [0:3];
      int          e0;
      e0 = errors;
      take_bits(32, v);
      bus_write(reg_ctrl, v);
      bus_read(reg_ctrl, d);
      check("control", d, v);
      take_bits(32, v);
      bus_write(reg_cpb, v);
      bus_read(reg_cpb, d);
      check("cycles_per_bit", d, v);
      for (int i = 0; i < 4; i++)
      begin
         take_bits(32, scratch_exp[i]);
         bus_write(4'(12 + i), scratch_exp[i]);
      end
      for (int i = 0; i < 4; i++)
      begin
         bus_read(4'(12 + i), d);
         check("scratch", d, scratch_exp[i]);
      end
      bus_read(4'd8, d);
      check("unmapped read", d, 32'd0);
      bus_write(reg_ctrl, 32'd0);
      bus_write(reg_cpb, 32'(bit_cycles));   // Short frames from here on
      test_done("register access", e0);
   endtask

   task automatic test_transmit();
      logic [31:0] d;
      logic [31:0] v;
      logic [7:0]  got;
      logic        start_bit;
      logic        stop_bit;
      logic        went_low;
      int          e0;
      e0 = errors;
      bus_write(reg_ctrl, 32'd1 << ctrl_tx_en);
      take_bits(8, v);
      bus_write(reg_dr, v);
      bus_read(reg_tstat, d);
      check("tx status while sending", d, 32'd0);
      capture_byte(got, start_bit, stop_bit);
      check("txd start bit", 32'(start_bit), 32'd0);
      check("txd byte", 32'(got), {24'd0, v[7:0]});
      check("txd stop bit", 32'(stop_bit), 32'd1);
      wait_reg(reg_tstat, 32'd1, 32'd1, "transmit complete");
      // Disabled transmitter ignores data writes
      bus_write(reg_ctrl, 32'd0);
      take_bits(8, v);
      bus_write(reg_dr, v);
      went_low = 1'b0;
      repeat (10 * bit_cycles)
      begin
         if (txd !== 1'b1)
            went_low = 1'b1;
         @(posedge clk);
         #1;
      end
      check("txd idle with tx disabled", 32'(went_low), 32'd0);
      bus_read(reg_tstat, d);
      check("tx status with tx disabled", d, 32'd1);
      test_done("transmit", e0);
   endtask

   task automatic test_receive_queue();
      logic [31:0] d;
      logic [31:0] v;
      logic [7:0]  sent [0:4];
      logic [6:0]  occ;
      int          e0;
      e0 = errors;
      bus_write(reg_ctrl, 32'd1 << ctrl_rx_en);
      for (int i = 0; i < 5; i++)
      begin
         take_bits(8, v);
         sent[i] = v[7:0];
         send_byte(sent[i], 1'b1);
         rx_total++;
         wait_reg(reg_char_count, '1, 32'(rx_total), "received character");
      end
      bus_read(reg_rstat, d);
      check("rx status rxne", 32'(d[stat_rxne]), 32'd1);
      check("rx status head byte", 32'(d[15:8]), 32'(sent[0]));
      occ = d[22:16] - d[30:24];
      check("queue occupancy", 32'(occ), 32'd5);
      for (int i = 0; i < 5; i++)
      begin
         bus_read(reg_queue, d);
         check("queue peek", d, {24'd0, sent[i]});
         bus_read(reg_dr, d);
         check("data register", d, {24'd0, sent[i]});
         bus_write(reg_pop, 32'd0);
         bus_read(reg_rstat, d);
         occ = d[22:16] - d[30:24];
         check("queue occupancy", 32'(occ), 32'(4 - i));
      end
      check("rx status rxne after pops", 32'(d[stat_rxne]), 32'd0);
      bus_read(reg_char_count, d);
      check("char_count", d, 32'd5);
      // Frame sent with the receiver off stays out of the queue
      bus_write(reg_ctrl, 32'd0);
      take_bits(8, v);
      send_byte(v[7:0], 1'b1);
      repeat (2 * bit_cycles) @(posedge clk);
      #1;
      bus_read(reg_rstat, d);
      check("rx status rxne with rx disabled", 32'(d[stat_rxne]), 32'd0);
      bus_read(reg_char_count, d);
      check("char_count with rx disabled", d, 32'(rx_total));
      test_done("receive and queue", e0);
   endtask

   task automatic test_break();
      logic [31:0] d;
      logic [31:0] v;
      int          e0;
      e0 = errors;
      bus_write(reg_ctrl, 32'd1 << ctrl_rx_en);
      send_byte(8'h00, 1'b0);
      wait_reg(reg_rstat, 32'd1 << stat_break, 32'd1 << stat_break, "break flag");
      bus_read(reg_rstat, d);
      check("rx status rxne after break", 32'(d[stat_rxne]), 32'd0);
      take_bits(8, v);
      send_byte(v[7:0], 1'b1);
      rx_total++;
      wait_reg(reg_char_count, '1, 32'(rx_total), "character after break");
      bus_read(reg_rstat, d);
      check("rx status break", 32'(d[stat_break]), 32'd0);
      check("rx status rxne", 32'(d[stat_rxne]), 32'd1);
      bus_read(reg_dr, d);
      check("data register after break", d, {24'd0, v[7:0]});
      bus_write(reg_pop, 32'd0);
      test_done("break", e0);
   endtask

   initial
   begin
      reset = 1'b1;
      cs    = 1'b0;
      wen   = 1'b0;
      addr  = '0;
      din   = '0;
      rxd   = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      test_reset_values();
      test_register_access();
      test_transmit();
      test_receive_queue();
      test_break();
      $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire
